//--- design/axi_write_params.svh
`ifndef AXI_WRITE_PARAMS_SVH
`define AXI_WRITE_PARAMS_SVH

// Bus widths
`define AXI_ADDR_W    32
`define AXI_DATA_W    32
`define AXI_STRB_W    (`AXI_DATA_W / 8)
`define AXI_OFFSET_W  2    // Lane select bits
`define AXI_LEN_W     8

// Request size in bytes
`define REQ_LEN_W     12   // At most 4095 bytes

// Burst limit in beats
`define AXI_MAX_BEATS 16

`endif

//--- design/axi_write_pkg.sv
`default_nettype none

`include "axi_write_params.svh"

package axi_write_pkg;

   typedef logic [`AXI_ADDR_W-1:0]   addr_t;
   typedef logic [`AXI_DATA_W-1:0]   data_t;
   typedef logic [`AXI_STRB_W-1:0]   strb_t;
   typedef logic [`AXI_OFFSET_W-1:0] offset_t;
   typedef logic [`REQ_LEN_W-1:0]    beats_t;  // Beats, words and burst counts

   typedef enum logic [2:0] {
      IDLE = 3'd0,
      PLAN = 3'd1,  // Latch planner results
      ADDR = 3'd2,
      DATA = 3'd3,
      RESP = 3'd4   // Drain outstanding responses
   } wr_state_e;

endpackage

`default_nettype wire

//--- design/burst_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_write_params.svh"

module burst_planner
   import axi_write_pkg::*;
(
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    plan_start_i,
   input  wire                    burst_accept_i,
   input  wire addr_t             address_i,
   input  wire beats_t            length_i,
   output addr_t                  burst_addr_o,
   output logic [`AXI_LEN_W-1:0]  burst_len_o,
   output strb_t                  first_strb_o,
   output strb_t                  final_strb_o,
   output beats_t                 total_beats_o,
   output beats_t                 req_words_o,
   output logic                   last_burst_o,
   output logic                   last_burst_next_o
);

   localparam int PAGE_BITS  = 12;
   localparam int PAGE_WORDS = (1 << PAGE_BITS) / `AXI_STRB_W;
   localparam int TO_PAGE_W  = PAGE_BITS - `AXI_OFFSET_W + 1;
   localparam int SPAN_W     = `REQ_LEN_W + 1;

   localparam strb_t STRB_ONES = '1;

   addr_t                 addr_q;
   beats_t                remain_q;   // Beats not yet given to a burst
   beats_t                beats;
   beats_t                total_c;
   logic [TO_PAGE_W-1:0]  to_page;
   logic [SPAN_W-1:0]     span;
   offset_t               start_off;
   offset_t               end_lane;
   addr_t                 burst_end;

   // Request geometry from the start address and byte length
   always_comb begin
      start_off = address_i[`AXI_OFFSET_W-1:0];
      span      = {1'b0, length_i} + SPAN_W'(start_off) + SPAN_W'(`AXI_STRB_W - 1);
      total_c   = beats_t'(span >> `AXI_OFFSET_W);
      end_lane  = offset_t'(length_i + beats_t'(start_off) - beats_t'(1));
   end

   // Smallest of remaining beats, burst limit and room left in the 4 KB page
   always_comb begin
      to_page = TO_PAGE_W'(PAGE_WORDS) - {1'b0, addr_q[PAGE_BITS-1:`AXI_OFFSET_W]};
      beats   = remain_q;
      if (beats > beats_t'(`AXI_MAX_BEATS)) begin
         beats = beats_t'(`AXI_MAX_BEATS);
      end
      if (beats > beats_t'(to_page)) begin
         beats = beats_t'(to_page);
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         remain_q <= '0;
      end else if (plan_start_i) begin
         remain_q <= total_c;
      end else if (burst_accept_i) begin
         remain_q <= remain_q - beats;
      end
   end

   always_ff @(posedge clk_i) begin
      if (plan_start_i) begin
         addr_q        <= address_i;
         first_strb_o  <= STRB_ONES << start_off;
         final_strb_o  <= STRB_ONES >> (`AXI_STRB_W - 1 - end_lane);
         total_beats_o <= total_c;
         req_words_o   <= beats_t'((length_i + (`AXI_STRB_W - 1)) >> `AXI_OFFSET_W);
      end else if (burst_accept_i) begin
         // Later bursts start word aligned
         addr_q <= {addr_q[`AXI_ADDR_W-1:`AXI_OFFSET_W] + beats, {`AXI_OFFSET_W{1'b0}}};
      end
   end

   assign burst_addr_o      = addr_q;
   assign burst_len_o       = `AXI_LEN_W'(beats - beats_t'(1));
   assign last_burst_o      = (remain_q == '0);   // Accepted burst was the final one
   assign last_burst_next_o = (remain_q == beats);

   assign burst_end = {addr_q[`AXI_ADDR_W-1:`AXI_OFFSET_W] + beats - 1'b1,
                       {`AXI_OFFSET_W{1'b1}}};

   a_page_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      burst_accept_i |-> beats != '0 &&
         burst_end[`AXI_ADDR_W-1:PAGE_BITS] == addr_q[`AXI_ADDR_W-1:PAGE_BITS]);

endmodule

`default_nettype wire

//--- design/lane_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_write_params.svh"

module lane_aligner
   import axi_write_pkg::*;
(
   input  wire          clk_i,
   input  wire          rst_i,
   input  wire offset_t offset_i,
   input  wire data_t   data_i,
   input  wire          take_i,
   input  wire          flush_i,
   output data_t        data_o
);

   localparam int DATA_W = `AXI_DATA_W;

   data_t                prev_q;    // Last consumed requester word
   logic [2*DATA_W-1:0]  joined;
   logic [2*DATA_W-1:0]  shifted;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         prev_q <= '0;
      end else if (flush_i) begin
         prev_q <= '0;              // Final beat of the request sent
      end else if (take_i) begin
         prev_q <= data_i;
      end
   end

   // Lanes below the offset take the top bytes of the previous word,
   // the rest take the low bytes of the current one
   always_comb begin
      joined  = {data_i, prev_q};
      shifted = joined >> (8 * (`AXI_STRB_W - offset_i));   // Offset 0 passes data_i
   end

   assign data_o = shifted[DATA_W-1:0];

endmodule

`default_nettype wire

//--- design/beat_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_write_params.svh"

module beat_controller
   import axi_write_pkg::*;
(
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        m_wvalid_i,
   output logic                       m_wready_o,
   output logic                       m_wlast_o,
   output logic                       m_wdone_o,
   output logic                       m_werr_o,
   input  wire addr_t                 burst_addr_i,
   input  wire [`AXI_LEN_W-1:0]       burst_len_i,
   input  wire strb_t                 first_strb_i,
   input  wire strb_t                 final_strb_i,
   input  wire beats_t                total_beats_i,
   input  wire beats_t                req_words_i,
   input  wire                        last_burst_i,
   input  wire                        last_burst_next_i,
   output logic                       plan_start_o,
   output logic                       burst_accept_o,
   output logic                       word_take_o,
   output logic                       flush_o,
   output offset_t                    offset_o,
   output addr_t                      axi_awaddr_o,
   output logic [`AXI_LEN_W-1:0]      axi_awlen_o,
   output logic                       axi_awvalid_o,
   input  wire                        axi_awready_i,
   output strb_t                      axi_wstrb_o,
   output logic                       axi_wlast_o,
   output logic                       axi_wvalid_o,
   input  wire                        axi_wready_i,
   input  wire [1:0]                  axi_bresp_i,
   input  wire                        axi_bvalid_i,
   output logic                       axi_bready_o
);

   localparam strb_t STRB_ONES = '1;

   wr_state_e              state_q;
   addr_t                  awaddr_q;
   logic [`AXI_LEN_W-1:0]  awlen_q;
   logic [`AXI_LEN_W-1:0]  beat_q;     // Beat within the burst
   strb_t                  wstrb_q;
   strb_t                  head_strb;
   strb_t                  next_strb;
   offset_t                offset_q;
   beats_t                 sent_q;     // Beats of the request sent
   beats_t                 words_q;    // Requester words consumed
   beats_t                 pending_q;  // Bursts still owing a response
   logic                   awvalid_q;
   logic                   first_q;
   logic                   done_q;
   logic                   err_q;
   logic                   words_left;
   logic                   aw_hs;
   logic                   w_hs;
   logic                   b_hs;
   logic                   burst_end;
   logic                   req_end;

   assign aw_hs      = axi_awvalid_o && axi_awready_i;
   assign w_hs       = axi_wvalid_o && axi_wready_i;
   assign b_hs       = axi_bvalid_i && axi_bready_o;
   assign words_left = (words_q != req_words_i);
   assign burst_end  = (beat_q == awlen_q);
   assign req_end    = (sent_q == total_beats_i - beats_t'(1));

   assign axi_awaddr_o  = awaddr_q;
   assign axi_awlen_o   = awlen_q;
   assign axi_awvalid_o = awvalid_q;
   assign axi_wstrb_o   = wstrb_q;
   assign axi_wvalid_o  = (state_q == DATA) && (words_left ? m_wvalid_i : 1'b1);  // Else flush
   assign axi_wlast_o   = axi_wvalid_o && burst_end;
   assign axi_bready_o  = (state_q == DATA) || (state_q == RESP);

   assign m_wready_o = (state_q == DATA) && words_left && axi_wready_i;
   assign m_wlast_o  = w_hs && req_end;
   assign m_wdone_o  = done_q;
   assign m_werr_o   = err_q;

   // Requester may still hold valid in the done cycle
   assign plan_start_o   = (state_q == IDLE) && m_wvalid_i && !done_q;
   assign burst_accept_o = aw_hs;
   assign word_take_o    = m_wvalid_i && m_wready_o;
   assign flush_o        = w_hs && req_end;
   assign offset_o       = offset_q;

   always_comb begin
      head_strb = first_q ? first_strb_i : STRB_ONES;
      if (awlen_q == '0 && last_burst_next_i) begin
         head_strb = head_strb & final_strb_i;   // Single beat closing burst
      end
      next_strb = STRB_ONES;
      if (beat_q + 1'b1 == awlen_q && last_burst_i) begin
         next_strb = final_strb_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= IDLE;
         awvalid_q <= 1'b0;
         first_q   <= 1'b0;
         done_q    <= 1'b0;
         err_q     <= 1'b0;
         beat_q    <= '0;
         sent_q    <= '0;
         words_q   <= '0;
         pending_q <= '0;
      end else begin
         done_q <= 1'b0;
         if (word_take_o) words_q <= words_q + 1'b1;
         if (b_hs && axi_bresp_i != 2'b00) err_q <= 1'b1;
         case ({aw_hs, b_hs})
            2'b10:   pending_q <= pending_q + 1'b1;
            2'b01:   pending_q <= pending_q - 1'b1;
            default: pending_q <= pending_q;
         endcase
         case (state_q)
            IDLE: begin
               if (plan_start_o) begin
                  first_q <= 1'b1;
                  err_q   <= 1'b0;
                  sent_q  <= '0;
                  words_q <= '0;
                  state_q <= PLAN;
               end
            end
            PLAN: begin
               awvalid_q <= 1'b1;
               state_q   <= ADDR;
            end
            ADDR: begin
               if (axi_awready_i) begin
                  awvalid_q <= 1'b0;
                  first_q   <= 1'b0;
                  beat_q    <= '0;
                  state_q   <= DATA;
               end
            end
            DATA: begin
               if (w_hs) begin
                  beat_q <= beat_q + 1'b1;
                  sent_q <= sent_q + 1'b1;
                  if (burst_end) state_q <= last_burst_i ? RESP : PLAN;
               end
            end
            RESP: begin
               if (pending_q == '0 || (b_hs && pending_q == beats_t'(1))) begin
                  done_q  <= 1'b1;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == PLAN) begin
         awaddr_q <= burst_addr_i;
         awlen_q  <= burst_len_i;
         if (first_q) offset_q <= burst_addr_i[`AXI_OFFSET_W-1:0];  // Start lane
      end
      if (aw_hs) begin
         wstrb_q <= head_strb;
      end else if (w_hs && !burst_end) begin
         wstrb_q <= next_strb;
      end
   end

   a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_awvalid_o && !axi_awready_i |=>
         axi_awvalid_o && $stable(axi_awaddr_o) && $stable(axi_awlen_o));

   // Last beat of the closing burst is also the final beat of the request
   a_wlast: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_wlast_o && last_burst_i |-> req_end);

   a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
      state_q == IDLE |-> pending_q == '0);

endmodule

`default_nettype wire

//--- design/axi_write_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_write_params.svh"

module axi_write_top
   import axi_write_pkg::*;
(
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    m_wvalid_i,
   input  wire addr_t             m_waddr_i,
   input  wire beats_t            m_wlen_i,
   input  wire data_t             m_wdata_i,
   output logic                   m_wready_o,
   output logic                   m_wlast_o,
   output logic                   m_wdone_o,
   output logic                   m_werr_o,
   output addr_t                  axi_awaddr_o,
   output logic [`AXI_LEN_W-1:0]  axi_awlen_o,
   output logic                   axi_awvalid_o,
   input  wire                    axi_awready_i,
   output data_t                  axi_wdata_o,
   output strb_t                  axi_wstrb_o,
   output logic                   axi_wlast_o,
   output logic                   axi_wvalid_o,
   input  wire                    axi_wready_i,
   input  wire [1:0]              axi_bresp_i,
   input  wire                    axi_bvalid_i,
   output logic                   axi_bready_o
);

   addr_t                  burst_addr;
   logic [`AXI_LEN_W-1:0]  burst_len;
   strb_t                  first_strb;
   strb_t                  final_strb;
   beats_t                 total_beats;
   beats_t                 req_words;
   logic                   last_burst;
   logic                   last_burst_next;
   logic                   plan_start;
   logic                   burst_accept;
   logic                   word_take;
   logic                   flush;
   offset_t                offset;

   burst_planner i_planner (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .plan_start_i      (plan_start),
      .burst_accept_i    (burst_accept),
      .address_i         (m_waddr_i),
      .length_i          (m_wlen_i),
      .burst_addr_o      (burst_addr),
      .burst_len_o       (burst_len),
      .first_strb_o      (first_strb),
      .final_strb_o      (final_strb),
      .total_beats_o     (total_beats),
      .req_words_o       (req_words),
      .last_burst_o      (last_burst),
      .last_burst_next_o (last_burst_next)
   );

   lane_aligner i_aligner (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .offset_i (offset),
      .data_i   (m_wdata_i),
      .take_i   (word_take),
      .flush_i  (flush),
      .data_o   (axi_wdata_o)
   );

   beat_controller i_ctrl (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .m_wvalid_i        (m_wvalid_i),
      .m_wready_o        (m_wready_o),
      .m_wlast_o         (m_wlast_o),
      .m_wdone_o         (m_wdone_o),
      .m_werr_o          (m_werr_o),
      .burst_addr_i      (burst_addr),
      .burst_len_i       (burst_len),
      .first_strb_i      (first_strb),
      .final_strb_i      (final_strb),
      .total_beats_i     (total_beats),
      .req_words_i       (req_words),
      .last_burst_i      (last_burst),
      .last_burst_next_i (last_burst_next),
      .plan_start_o      (plan_start),
      .burst_accept_o    (burst_accept),
      .word_take_o       (word_take),
      .flush_o           (flush),
      .offset_o          (offset),
      .axi_awaddr_o      (axi_awaddr_o),
      .axi_awlen_o       (axi_awlen_o),
      .axi_awvalid_o     (axi_awvalid_o),
      .axi_awready_i     (axi_awready_i),
      .axi_wstrb_o       (axi_wstrb_o),
      .axi_wlast_o       (axi_wlast_o),
      .axi_wvalid_o      (axi_wvalid_o),
      .axi_wready_i      (axi_wready_i),
      .axi_bresp_i       (axi_bresp_i),
      .axi_bvalid_i      (axi_bvalid_i),
      .axi_bready_o      (axi_bready_o)
   );

endmodule

`default_nettype wire

//--- verification/tb_axi_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_write_params.svh"

module tb_axi_write
   import axi_write_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int MEM_BYTES  = 8192;
   localparam int NUM_REQ    = 23;

   logic                   clk_i;
   logic                   rst_i;
   logic                   m_wvalid_i;
   addr_t                  m_waddr_i;
   beats_t                 m_wlen_i;
   data_t                  m_wdata_i;
   logic                   m_wready_o;
   logic                   m_wlast_o;
   logic                   m_wdone_o;
   logic                   m_werr_o;
   addr_t                  axi_awaddr_o;
   logic [`AXI_LEN_W-1:0]  axi_awlen_o;
   logic                   axi_awvalid_o;
   logic                   axi_awready_i;
   data_t                  axi_wdata_o;
   strb_t                  axi_wstrb_o;
   logic                   axi_wlast_o;
   logic                   axi_wvalid_o;
   logic                   axi_wready_i;
   logic [1:0]             axi_bresp_i;
   logic                   axi_bvalid_i;
   logic                   axi_bready_o;

   logic [7:0]   mem [MEM_BYTES];
   addr_t        open_addr[$];      // Bursts still taking W beats
   int           open_len[$];
   addr_t        log_addr[$];       // Every AW of the current request
   int           log_len[$];
   logic [1:0]   resp_q[$];
   int           beat_idx;
   logic         stall_en;
   logic         inject_err;
   logic [31:0]  stall_rng;
   logic [31:0]  req_rng;
   int           wlast_count;
   int           errors;
   int           cur_base;
   int           cur_len;
   int           cur_tag;
   logic         expect_err;
   logic         done_err;
   int           req_count;
   int           checked_count;
   event         check_ev;

   axi_write_top i_dut (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] fill_byte(input int a);
      return 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
   endfunction

   function automatic logic [7:0] stream_byte(input int tag, input int idx);
      return 8'(idx * 13 + tag * 57 + 60) ^ 8'(idx >> 8);
   endfunction

   // Expected memory byte after a request
   function automatic logic [7:0] ref_byte(input int a, input int base, input int len,
                                           input int tag);
      if (a >= base && a < base + len) begin
         return stream_byte(tag, a - base);
      end else begin
         return fill_byte(a);
      end
   endfunction

   function automatic data_t word_of(input int tag, input int w);
      data_t d;
      for (int j = 0; j < `AXI_STRB_W; j++) d[8*j +: 8] = stream_byte(tag, 4 * w + j);
      return d;
   endfunction

   task automatic run_request(input int base, input int len, input int tag, input logic err);
      int   words;
      int   idx;
      logic take;
      logic done;
      words = (len + 3) / 4;
      idx   = 0;
      done  = 1'b0;
      for (int a = 0; a < MEM_BYTES; a++) mem[a] = fill_byte(a);
      log_addr.delete();
      log_len.delete();
      wlast_count = 0;
      cur_base    = base;
      cur_len     = len;
      cur_tag     = tag;
      inject_err  = err;   // Hits the first burst response
      expect_err  = err;
      m_waddr_i   = addr_t'(base);
      m_wlen_i    = beats_t'(len);
      m_wdata_i   = word_of(tag, 0);
      m_wvalid_i  = 1'b1;
      while (!done) begin
         @(negedge clk_i);
         take = m_wready_o;
         @(posedge clk_i);
         #2;
         if (take) begin
            idx++;
            m_wdata_i = (idx < words) ? word_of(tag, idx) : '0;
         end
         if (m_wdone_o) begin
            done       = 1'b1;
            done_err   = m_werr_o;
            m_wvalid_i = 1'b0;
         end
      end
      req_count++;
      -> check_ev;
      wait (checked_count == req_count);
   endtask

   // AXI slave memory sampled mid-cycle and updated after the edge
   initial begin : axi_slave
      logic   aw_fire;
      logic   w_fire;
      logic   b_fire;
      logic   req_last;
      addr_t  aw_a;
      int     aw_l;
      data_t  wd;
      strb_t  ws;
      logic   wl;
      addr_t  wa;
      strb_t  exp_strb;
      forever begin
         @(negedge clk_i);
         aw_fire  = axi_awvalid_o && axi_awready_i;
         aw_a     = axi_awaddr_o;
         aw_l     = axi_awlen_o;
         w_fire   = axi_wvalid_o && axi_wready_i;
         wd       = axi_wdata_o;
         ws       = axi_wstrb_o;
         wl       = axi_wlast_o;
         b_fire   = axi_bvalid_i && axi_bready_o;
         req_last = m_wlast_o;
         @(posedge clk_i);
         #2;
         if (req_last) wlast_count++;
         if (aw_fire) begin
            open_addr.push_back(aw_a);
            open_len.push_back(aw_l);
            log_addr.push_back(aw_a);
            log_len.push_back(aw_l);
         end
         if (b_fire) void'(resp_q.pop_front());
         if (w_fire && open_addr.size() == 0) begin
            errors++;
            $display("W beat arrived with no open burst at %0t", $time);
         end else if (w_fire) begin
            wa = (open_addr[0] & ~addr_t'(3)) + addr_t'(4 * beat_idx);
            for (int j = 0; j < `AXI_STRB_W; j++) begin
               exp_strb[j] = (int'(wa) + j >= cur_base) && (int'(wa) + j < cur_base + cur_len);
            end
            if (ws !== exp_strb) begin
               errors++;
               $display("Mismatch axi_wstrb_o at 0x%h: got 0x%h, expected 0x%h",
                        wa, ws, exp_strb);
            end
            if (wl !== (beat_idx == open_len[0])) begin
               errors++;
               $display("Mismatch axi_wlast_o at 0x%h: got 0x%h, expected 0x%h",
                        wa, wl, beat_idx == open_len[0]);
            end
            for (int j = 0; j < `AXI_STRB_W; j++) begin
               if (ws[j]) mem[(int'(wa) + j) % MEM_BYTES] = wd[8*j +: 8];
            end
            beat_idx++;
            if (wl) begin
               void'(open_addr.pop_front());
               void'(open_len.pop_front());
               beat_idx = 0;
               resp_q.push_back(inject_err ? 2'b10 : 2'b00);   // SLVERR or OKAY
               inject_err = 1'b0;
            end
         end
         axi_bvalid_i  = (resp_q.size() != 0);
         axi_bresp_i   = (resp_q.size() != 0) ? resp_q[0] : 2'b00;
         stall_rng     = lcg_next(stall_rng);
         axi_awready_i = !stall_en || (stall_rng[29:28] != 2'b00);
         axi_wready_i  = !stall_en || (stall_rng[27:26] != 2'b00);
      end
   end

   initial begin : compare_results
      int          rem;
      int          a;
      int          n;
      int          exp_len;
      int          to_page;
      addr_t       last_b;
      logic [7:0]  exp_b;
      forever begin
         @(check_ev);
         for (int m = 0; m < MEM_BYTES; m++) begin
            exp_b = ref_byte(m, cur_base, cur_len, cur_tag);
            if (mem[m] !== exp_b) begin
               errors++;
               $display("Mismatch mem[0x%04h] in request %0d: got 0x%02h, expected 0x%02h",
                        m, req_count, mem[m], exp_b);
            end
         end
         // Expected bursts from remaining beats, burst limit and page room
         rem = (cur_len + cur_base % 4 + 3) / 4;
         a   = cur_base;
         n   = 0;
         while (rem > 0) begin
            to_page = (4096 - (a & ~3) % 4096) / 4;
            exp_len = rem;
            if (exp_len > `AXI_MAX_BEATS) exp_len = `AXI_MAX_BEATS;
            if (exp_len > to_page) exp_len = to_page;
            if (n < log_addr.size()) begin
               if (log_addr[n] !== addr_t'(a)) begin
                  errors++;
                  $display("Mismatch axi_awaddr_o burst %0d: got 0x%h, expected 0x%h",
                           n, log_addr[n], a);
               end
               if (log_len[n] != exp_len - 1) begin
                  errors++;
                  $display("Mismatch axi_awlen_o burst %0d: got 0x%h, expected 0x%h",
                           n, log_len[n], exp_len - 1);
               end
            end
            rem -= exp_len;
            a    = (a & ~3) + 4 * exp_len;
            n++;
         end
         if (log_addr.size() != n) begin
            errors++;
            $display("Mismatch AW burst count: got 0x%h, expected 0x%h", log_addr.size(), n);
         end
         for (int i = 0; i < log_addr.size(); i++) begin
            last_b = (log_addr[i] & ~addr_t'(3)) + addr_t'(4 * log_len[i] + 3);
            if (last_b[`AXI_ADDR_W-1:12] != log_addr[i][`AXI_ADDR_W-1:12]) begin
               errors++;
               $display("Burst at 0x%h crosses a 4 KB page", log_addr[i]);
            end
         end
         if (wlast_count != 1) begin
            errors++;
            $display("Mismatch m_wlast_o pulses: got 0x%h, expected 0x1", wlast_count);
         end
         if (done_err !== expect_err) begin
            errors++;
            $display("Mismatch m_werr_o: got 0x%h, expected 0x%h", done_err, expect_err);
         end
         checked_count++;
      end
   end

   initial begin : watchdog
      #(NUM_REQ * (4095 / 4 + 64) * CLK_PERIOD);
      $display("Run timed out before all requests completed");
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : stimulus
      int len;
      int base;
      clk_i         = 1'b0;
      rst_i         = 1'b1;
      m_wvalid_i    = 1'b0;
      m_waddr_i     = '0;
      m_wlen_i      = '0;
      m_wdata_i     = '0;
      axi_awready_i = 1'b1;
      axi_wready_i  = 1'b1;
      axi_bresp_i   = 2'b00;
      axi_bvalid_i  = 1'b0;
      stall_en      = 1'b0;
      inject_err    = 1'b0;
      stall_rng     = 32'd91;
      req_rng       = 32'd91;
      beat_idx      = 0;
      errors        = 0;
      req_count     = 0;
      checked_count = 0;
      repeat (4) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      @(posedge clk_i);
      #2;
      run_request(32'h100, 4, 1, 1'b0);    // Single aligned word
      run_request(32'h201, 1, 2, 1'b0);
      run_request(32'h302, 7, 3, 1'b0);
      run_request(32'h403, 10, 4, 1'b0);
      run_request(32'h505, 3, 5, 1'b0);
      run_request(32'h606, 13, 6, 1'b0);
      run_request(32'h800, 200, 7, 1'b0);  // Split by burst limit
      run_request(32'hfa1, 120, 8, 1'b0);  // Page boundary mid request
      run_request(32'hc02, 4095, 9, 1'b0);
      stall_en = 1'b1;
      for (int i = 0; i < 12; i++) begin
         req_rng = lcg_next(req_rng);
         len     = 1 + int'(req_rng[30:16]) % 600;
         req_rng = lcg_next(req_rng);
         base    = int'(req_rng[30:16]) % (MEM_BYTES - len);
         run_request(base, len, 20 + i, 1'b0);
      end
      run_request(32'h1100, 200, 40, 1'b1);
      run_request(32'h1400, 64, 41, 1'b0);  // Error flag must be clear again
      $display("Requests %0d, errors %0d", req_count, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/axi_write_pkg.sv
design/burst_planner.sv
design/lane_aligner.sv
design/beat_controller.sv
design/axi_write_top.sv
verification/tb_axi_write.sv

//--- Bender.yml
package:
  name: axi_write

sources:
  - include_dirs:
      - design
    files:
      - design/axi_write_pkg.sv
      - design/burst_planner.sv
      - design/lane_aligner.sv
      - design/beat_controller.sv
      - design/axi_write_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_axi_write.sv
